/* id_pkg.sv */
// shared widths, types, opcodes and alu codes of the decode stage, referenced by scoped names
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int ALU_OP_WD   = 4;

  typedef logic [XLEN-1:0]        word_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [ALU_OP_WD-1:0]   alu_op_t;

  // alu operations
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  localparam alu_op_t ALU_PASS2 = 4'd10; // lui, operand 2 straight through

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef struct packed {
    inst_t inst;
    word_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       src1_pc;  // operand 1 is pc
    logic       src2_imm; // operand 2 is imm
    logic       link;     // result is pc+4
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;   // funct3
    logic       invalid;
  } ctrl_t;

  typedef struct packed {
    word_t     rs1data;
    word_t     rs2data;
    word_t     imm;
    word_t     pc;
    gpr_addr_t rd;
    ctrl_t     ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } br_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    word_t     wdata;
  } wb_t;

endpackage

/* id_pipe_reg.sv */
// fetch-to-decode pipeline register with valid/allowin flow control
`timescale 1ns/10ps

module id_pipe_reg (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds_bus,
  input  logic              i_es_allowin,
  input  logic              i_ready_go,
  output logic              o_ds_allowin,
  output logic              o_ds_valid_go,
  output id_pkg::inst_t     o_inst,
  output id_pkg::word_t     o_pc
);

  logic              ds_valid;
  id_pkg::fs_to_ds_t bus_r;

  // empty, or the held instruction leaves this cycle
  assign o_ds_allowin  = !ds_valid || (i_ready_go && i_es_allowin);
  assign o_ds_valid_go = ds_valid && i_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid; // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      bus_r <= i_fs_to_ds_bus;
    end
  end

  assign o_inst = bus_r.inst;
  assign o_pc   = bus_r.pc;

endmodule

/* id_hazard.sv */
// raw hazard check of decoded sources against execute, memory and write-back destinations
`timescale 1ns/10ps

module id_hazard (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  output logic              o_ready_go
);

  logic es_hit;
  logic ms_hit;
  logic ws_hit;

  // x0 as destination never blocks
  assign es_hit = (i_es_rd != '0) && ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));
  assign ms_hit = (i_ms_rd != '0) && ((i_ms_rd == i_rs1) || (i_ms_rd == i_rs2));
  assign ws_hit = (i_ws_rd != '0) && ((i_ws_rd == i_rs1) || (i_ws_rd == i_rs2));

  assign o_ready_go = !(es_hit || ms_hit || ws_hit);

endmodule

/* id_gpr.sv */
// general register file, two combinational read ports and one write port from write-back
`timescale 1ns/10ps

module id_gpr #(
  parameter int NUM_REGS = 32
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::word_t     o_rdata1,
  output id_pkg::word_t     o_rdata2,
  input  id_pkg::wb_t       i_wb
);

  id_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.waddr != '0) && (i_wb.waddr < NUM_REGS)) begin
      regs[i_wb.waddr] <= i_wb.wdata; // no bypass to the read ports
    end
  end

  // x0 and indices past the file read zero
  assign o_rdata1 = ((i_raddr1 != '0) && (i_raddr1 < NUM_REGS)) ? regs[i_raddr1] : '0;
  assign o_rdata2 = ((i_raddr2 != '0) && (i_raddr2 < NUM_REGS)) ? regs[i_raddr2] : '0;

endmodule

/* id_decoder.sv */
// rv64i subset decoder, builds register indices, immediate and execute control from one word
`timescale 1ns/10ps

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::word_t     o_imm,
  output id_pkg::ctrl_t     o_ctrl,
  output logic              o_is_jal,
  output logic              o_is_jalr,
  output logic              o_is_branch
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          legal;
  id_pkg::word_t imm_i;
  id_pkg::word_t imm_s;
  id_pkg::word_t imm_b;
  id_pkg::word_t imm_u;
  id_pkg::word_t imm_j;

  // alt picks sub/sra over add/srl
  function automatic id_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15]; // raw fields, whatever the format
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{(id_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(id_pkg::XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(id_pkg::XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(id_pkg::XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(id_pkg::XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl        = '0;
    o_ctrl.alu_op = id_pkg::ALU_ADD;
    o_ctrl.mem_op = funct3;
    o_imm         = '0;
    o_is_jal      = 1'b0;
    o_is_jalr     = 1'b0;
    o_is_branch   = 1'b0;
    legal         = 1'b1;
    case (opcode)
      id_pkg::OPC_OP: begin
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = alu_sel(funct3, funct7[5]);
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      id_pkg::OPC_OP_IMM: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.alu_op   = alu_sel(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_imm           = imm_i; // shamt sits in the low 6 bits
        if (funct3 == 3'b001) begin
          legal = (i_inst[31:26] == 6'b000000);
        end else if (funct3 == 3'b101) begin
          legal = (i_inst[31:26] == 6'b000000) || (i_inst[31:26] == 6'b010000);
        end
      end
      id_pkg::OPC_LUI: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.alu_op   = id_pkg::ALU_PASS2;
        o_imm           = imm_u;
      end
      id_pkg::OPC_AUIPC: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_imm           = imm_u;
      end
      id_pkg::OPC_JAL: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.src1_pc  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.link     = 1'b1;
        o_imm           = imm_j;
        o_is_jal        = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_ctrl.link     = 1'b1;
        o_imm           = imm_i;
        o_is_jalr       = 1'b1;
        legal           = (funct3 == 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        legal       = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      id_pkg::OPC_LOAD: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_imm           = imm_i;
        legal           = (funct3 != 3'b111); // no ldu in rv64i
      end
      id_pkg::OPC_STORE: begin
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.src2_imm = 1'b1;
        o_imm           = imm_s;
        legal           = !funct3[2];
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      o_ctrl.invalid = 1'b1;
      o_ctrl.gpr_wen = 1'b0;
      o_ctrl.mem_ren = 1'b0;
      o_ctrl.mem_wen = 1'b0;
      o_is_jal       = 1'b0;
      o_is_jalr      = 1'b0;
      o_is_branch    = 1'b0;
    end
  end

endmodule

/* id_branch.sv */
// branch unit, resolves the taken flag and target of jal, jalr and conditional branches
`timescale 1ns/10ps

module id_branch (
  input  id_pkg::word_t i_rs1data,
  input  id_pkg::word_t i_rs2data,
  input  id_pkg::word_t i_pc,
  input  id_pkg::word_t i_imm,
  input  logic [2:0]    i_funct3,
  input  logic          i_is_jal,
  input  logic          i_is_jalr,
  input  logic          i_is_branch,
  output logic          o_taken,
  output id_pkg::word_t o_target
);

  logic          eq;
  logic          lt;
  logic          ltu;
  logic          cond;
  id_pkg::word_t pc_target;
  id_pkg::word_t reg_target;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_funct3)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = lt;
      3'b101:  cond = !lt;  // ge
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu; // geu
      default: cond = 1'b0;
    endcase
  end

  assign pc_target  = i_pc + i_imm;
  assign reg_target = (i_rs1data + i_imm) & ~id_pkg::word_t'(1); // jalr clears bit 0

  assign o_taken  = i_is_jal || i_is_jalr || (i_is_branch && cond);
  assign o_target = i_is_jalr ? reg_target : pc_target;

endmodule

/* id_stage.sv */
// decode stage top, wires the pipeline register, register file, decoder, hazard and branch units
`timescale 1ns/10ps

module id_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic              i_clk,
  input  logic              i_reset,
  // from fetch
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds_bus,
  output logic              o_ds_allowin,
  // to execute
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es_bus,
  input  logic              i_es_allowin,
  // to fetch
  output id_pkg::br_t       o_br_bus,
  // write back
  input  id_pkg::wb_t       i_wb,
  // in-flight destinations
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd
);

  id_pkg::inst_t     ds_inst;
  id_pkg::word_t     ds_pc;
  logic              ready_go;
  id_pkg::gpr_addr_t rs1;
  id_pkg::gpr_addr_t rs2;
  id_pkg::gpr_addr_t rd;
  id_pkg::word_t     rs1data;
  id_pkg::word_t     rs2data;
  id_pkg::word_t     imm;
  id_pkg::ctrl_t     ctrl;
  logic              is_jal;
  logic              is_jalr;
  logic              is_branch;
  logic              br_taken;
  id_pkg::word_t     br_target;

  assign o_ds_to_es_bus = '{rs1data: rs1data, rs2data: rs2data, imm: imm,
                            pc: ds_pc, rd: rd, ctrl: ctrl};
  assign o_br_bus = '{taken: o_ds_to_es_valid && br_taken, target: br_target};

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .i_ready_go       (ready_go),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid_go    (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc)
  );

  id_hazard u_hazard (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .o_ready_go (ready_go)
  );

  id_gpr #(
    .NUM_REGS (NUM_REGS)
  ) u_gpr (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data),
    .i_wb     (i_wb)
  );

  id_decoder u_decoder (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_ctrl      (ctrl),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_is_branch (is_branch)
  );

  id_branch u_branch (
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .i_pc        (ds_pc),
    .i_imm       (imm),
    .i_funct3    (ds_inst[14:12]),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_is_branch (is_branch),
    .o_taken     (br_taken),
    .o_target    (br_target)
  );

endmodule

/* id_stage_checker.sv */
// concurrent protocol assertions on the decode stage ports, attached to id_stage by bind
`timescale 1ns/10ps

module id_stage_checker (
  input logic              i_clk,
  input logic              i_reset,
  input logic              i_fs_to_ds_valid,
  input logic              o_ds_allowin,
  input logic              o_ds_to_es_valid,
  input id_pkg::ds_to_es_t o_ds_to_es_bus,
  input logic              i_es_allowin
);

  logic held; // occupancy seen from the ports

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      held <= 1'b0;
    end else if (o_ds_allowin) begin
      held <= i_fs_to_ds_valid;
    end
  end

  a_reset_quiet: assert property (@(posedge i_clk) i_reset |=> !o_ds_to_es_valid)
    else $error("valid high during reset or in the cycle after it");

  // register data may still change through write-back
  a_bus_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_ds_to_es_valid && !i_es_allowin) |=>
      $stable({o_ds_to_es_bus.imm, o_ds_to_es_bus.pc, o_ds_to_es_bus.rd, o_ds_to_es_bus.ctrl}))
    else $error("bus changed under back-pressure");

  a_empty_allowin: assert property (@(posedge i_clk) disable iff (i_reset)
    (!o_ds_to_es_valid && !held) |-> o_ds_allowin)
    else $error("allowin low while the stage is empty");

endmodule

bind id_stage id_stage_checker u_checker (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_fs_to_ds_valid (i_fs_to_ds_valid),
  .o_ds_allowin     (o_ds_allowin),
  .o_ds_to_es_valid (o_ds_to_es_valid),
  .o_ds_to_es_bus   (o_ds_to_es_bus),
  .i_es_allowin     (i_es_allowin)
);

/* tb_id_stage.sv */
// self-checking testbench for id_stage, random instruction stream against a reference model
`timescale 1ns/10ps

module tb_id_stage;

  localparam int NUM_CYCLES = 2000;

  logic              i_clk;
  logic              i_reset;
  logic              i_fs_to_ds_valid;
  id_pkg::fs_to_ds_t i_fs_to_ds_bus;
  logic              o_ds_allowin;
  logic              o_ds_to_es_valid;
  id_pkg::ds_to_es_t o_ds_to_es_bus;
  logic              i_es_allowin;
  id_pkg::br_t       o_br_bus;
  id_pkg::wb_t       i_wb;
  id_pkg::gpr_addr_t i_es_rd;
  id_pkg::gpr_addr_t i_ms_rd;
  id_pkg::gpr_addr_t i_ws_rd;

  logic [31:0]   seed = 32'h7dda_1809;
  int            errors = 0;
  int            checks = 0;
  logic          m_valid; // model of the held slot
  id_pkg::inst_t m_inst;
  id_pkg::word_t m_pc;
  id_pkg::word_t m_regs [32];

  id_stage #(.NUM_REGS(32)) u_id_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  // random word shaped into one of the kept classes, or left as is
  function automatic id_pkg::inst_t make_inst();
    logic [31:0] w;
    logic [31:0] pick;
    w = next_rand();
    pick = next_rand() % 10;
    case (pick)
      0: begin
        w[6:0] = id_pkg::OPC_OP;
        w[31:25] = w[30] ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = id_pkg::OPC_OP_IMM;
        if (w[13:12] == 2'b01) begin
          w[31:26] = w[30] ? 6'h10 : 6'h00; // slli, srli, srai
        end
      end
      2: w[6:0] = id_pkg::OPC_LUI;
      3: w[6:0] = id_pkg::OPC_AUIPC;
      4: w[6:0] = id_pkg::OPC_JAL;
      5: begin
        w[6:0] = id_pkg::OPC_JALR;
        if (w[25]) begin
          w[14:12] = 3'b000;
        end
      end
      6: begin
        w[6:0] = id_pkg::OPC_BRANCH;
        if (w[26]) begin
          w[24:20] = w[19:15]; // force equal operands
        end
      end
      7: w[6:0] = id_pkg::OPC_LOAD;
      8: w[6:0] = id_pkg::OPC_STORE;
      default: ;
    endcase
    return w;
  endfunction

  function automatic id_pkg::gpr_addr_t pick_rd();
    logic [31:0] r;
    r = next_rand();
    return ((r % 10) < 6) ? '0 : r[20:16];
  endfunction

  // kind: 0 none, 1 jal, 2 jalr, 3 branch
  function automatic void decode_ref(input id_pkg::inst_t w, output id_pkg::ctrl_t c,
                                     output id_pkg::word_t imm, output logic [1:0] kind);
    logic [2:0]      f3;
    logic            ok;
    id_pkg::alu_op_t ops [8];
    ops = '{id_pkg::ALU_ADD, id_pkg::ALU_SLL, id_pkg::ALU_SLT, id_pkg::ALU_SLTU,
            id_pkg::ALU_XOR, id_pkg::ALU_SRL, id_pkg::ALU_OR, id_pkg::ALU_AND};
    f3 = w[14:12];
    c = '0;
    c.mem_op = f3;
    imm = '0;
    kind = 2'd0;
    ok = 1'b1;
    case (w[6:0])
      id_pkg::OPC_OP: begin
        ok = (w[31:25] == 7'h00) || ((w[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        c.alu_op = ops[f3];
        if (w[30]) begin
          c.alu_op = (f3 == 3'd0) ? id_pkg::ALU_SUB : id_pkg::ALU_SRA;
        end
        c.gpr_wen = 1'b1;
      end
      id_pkg::OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          ok = (w[31:26] == 6'h00);
        end else if (f3 == 3'd5) begin
          ok = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
        end
        c.alu_op = ((f3 == 3'd5) && w[30]) ? id_pkg::ALU_SRA : ops[f3];
        c.gpr_wen = 1'b1;
        c.src2_imm = 1'b1;
        imm = {{52{w[31]}}, w[31:20]};
      end
      id_pkg::OPC_LUI: begin
        c.alu_op = id_pkg::ALU_PASS2;
        c.gpr_wen = 1'b1;
        c.src2_imm = 1'b1;
        imm = {{32{w[31]}}, w[31:12], 12'h000};
      end
      id_pkg::OPC_AUIPC: begin
        c.gpr_wen = 1'b1;
        c.src1_pc = 1'b1;
        c.src2_imm = 1'b1;
        imm = {{32{w[31]}}, w[31:12], 12'h000};
      end
      id_pkg::OPC_JAL: begin
        c.gpr_wen = 1'b1;
        c.src1_pc = 1'b1;
        c.src2_imm = 1'b1;
        c.link = 1'b1;
        imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        kind = 2'd1;
      end
      id_pkg::OPC_JALR: begin
        ok = (f3 == 3'd0);
        c.gpr_wen = 1'b1;
        c.src2_imm = 1'b1;
        c.link = 1'b1;
        imm = {{52{w[31]}}, w[31:20]};
        kind = 2'd2;
      end
      id_pkg::OPC_BRANCH: begin
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        kind = 2'd3;
      end
      id_pkg::OPC_LOAD: begin
        ok = (f3 != 3'd7);
        c.gpr_wen = 1'b1;
        c.mem_ren = 1'b1;
        c.src2_imm = 1'b1;
        imm = {{52{w[31]}}, w[31:20]};
      end
      id_pkg::OPC_STORE: begin
        ok = (f3 < 3'd4);
        c.mem_wen = 1'b1;
        c.src2_imm = 1'b1;
        imm = {{52{w[31]}}, w[31:25], w[11:7]};
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      c.invalid = 1'b1;
      c.gpr_wen = 1'b0;
      c.mem_ren = 1'b0;
      c.mem_wen = 1'b0;
      kind = 2'd0;
    end
  endfunction

  function automatic logic cond_ref(input logic [2:0] f3, input id_pkg::word_t a,
                                    input id_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic blocks(input id_pkg::gpr_addr_t d, input id_pkg::inst_t w);
    return (d != '0) && ((d == w[19:15]) || (d == w[24:20]));
  endfunction

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    i_fs_to_ds_valid = (r[1:0] != 2'b00);
    i_es_allowin = (r[3:2] != 2'b00);
    i_fs_to_ds_bus.inst = make_inst();
    i_fs_to_ds_bus.pc = {next_rand(), next_rand()} & ~64'h3;
    i_wb.wen = r[4];
    i_wb.waddr = (r[7:5] == 3'd0) ? '0 : r[12:8]; // extra writes to x0
    i_wb.wdata = {next_rand(), next_rand()};
    i_es_rd = pick_rd();
    i_ms_rd = pick_rd();
    i_ws_rd = pick_rd();
  endtask

  task automatic check_outputs();
    id_pkg::ctrl_t ec;
    id_pkg::word_t eimm;
    logic [1:0]    kind;
    id_pkg::word_t a;
    id_pkg::word_t b;
    id_pkg::word_t etgt;
    logic          ready;
    logic          etaken;
    decode_ref(m_inst, ec, eimm, kind);
    ready = !(blocks(i_es_rd, m_inst) || blocks(i_ms_rd, m_inst) || blocks(i_ws_rd, m_inst));
    a = m_regs[m_inst[19:15]];
    b = m_regs[m_inst[24:20]];
    etaken = (kind == 2'd1) || (kind == 2'd2) || ((kind == 2'd3) && cond_ref(m_inst[14:12], a, b));
    etgt = (kind == 2'd2) ? ((a + eimm) & ~64'h1) : (m_pc + eimm);
    check_val("allowin", 64'(o_ds_allowin), 64'(!m_valid || (ready && i_es_allowin)));
    check_val("valid", 64'(o_ds_to_es_valid), 64'(m_valid && ready));
    check_val("taken", 64'(o_br_bus.taken), 64'(m_valid && ready && etaken));
    if (m_valid) begin
      check_val("pc", o_ds_to_es_bus.pc, m_pc);
      check_val("rs1data", o_ds_to_es_bus.rs1data, a);
      check_val("rs2data", o_ds_to_es_bus.rs2data, b);
      check_val("rd", 64'(o_ds_to_es_bus.rd), 64'(m_inst[11:7]));
      check_val("invalid", 64'(o_ds_to_es_bus.ctrl.invalid), 64'(ec.invalid));
      check_val("gpr_wen", 64'(o_ds_to_es_bus.ctrl.gpr_wen), 64'(ec.gpr_wen));
      check_val("mem_ren", 64'(o_ds_to_es_bus.ctrl.mem_ren), 64'(ec.mem_ren));
      check_val("mem_wen", 64'(o_ds_to_es_bus.ctrl.mem_wen), 64'(ec.mem_wen));
      if (!ec.invalid) begin
        check_val("ctrl", 64'(o_ds_to_es_bus.ctrl), 64'(ec));
        check_val("imm", o_ds_to_es_bus.imm, eimm);
      end
      if (etaken) begin
        check_val("target", o_br_bus.target, etgt);
      end
    end
  endtask

  // state change at the coming rising edge
  task automatic update_model();
    logic ready;
    ready = !(blocks(i_es_rd, m_inst) || blocks(i_ms_rd, m_inst) || blocks(i_ws_rd, m_inst));
    if (!m_valid || (ready && i_es_allowin)) begin
      if (i_fs_to_ds_valid) begin
        m_inst = i_fs_to_ds_bus.inst;
        m_pc = i_fs_to_ds_bus.pc;
      end
      m_valid = i_fs_to_ds_valid;
    end
    if (i_wb.wen && (i_wb.waddr != '0)) begin
      m_regs[i_wb.waddr] = i_wb.wdata;
    end
  endtask

  initial begin
    #((NUM_CYCLES + 20) * 10 * 2);
    $display("timeout: the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    i_reset = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus = '0;
    i_es_allowin = 1'b0;
    i_wb = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    m_valid = 1'b0;
    m_inst = '0;
    m_pc = '0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    repeat (5) @(posedge i_clk);
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge i_clk);
      i_reset = 1'b0;
      drive_inputs();
      #4; // just before the rising edge
      check_outputs();
      update_model();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
id_pkg.sv
id_pipe_reg.sv
id_hazard.sv
id_gpr.sv
id_decoder.sv
id_branch.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_id_stage -f verilog.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -xF '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
